//--- hdl/panel_geom_pkg.sv
/* panel geometry limits, framebuffer addressing and colour types. */
package panel_geom_pkg;

    localparam int ROW_BITS = 4;
    localparam int COL_BITS = 5;
    localparam int BYTES_PER_PIXEL = 3;

    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [ROW_BITS:0] row_count_t; // one wider so a full height fits.
    typedef logic [COL_BITS:0] col_count_t;
    typedef logic [1:0] byte_idx_t;

    // ram address, row major.
    typedef struct packed {
        row_t row;
        col_t col;
        byte_idx_t byte_idx;
    } fb_addr_t;

    typedef logic [BYTES_PER_PIXEL-1:0][7:0] color_t; // index 2 is red.

    typedef struct packed {
        col_t x;
        row_t y;
        col_count_t width;
        row_count_t height;
    } area_t;

endpackage

//--- hdl/panel_bus_pkg.sv
/* host bus types, register map and command opcodes. */
package panel_bus_pkg;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [3:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        logic [7:0] prdata;
        logic pslverr;
    } apb_rsp_t;

    // one command byte offered to the dispatcher.
    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } cmd_byte_t;

    localparam logic [3:0] REG_CMD = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_FB_ADDR = 4'h8;
    localparam logic [3:0] REG_FB_DATA = 4'hC;

    localparam logic [7:0] OP_FILL_PANEL = 8'h01;
    localparam logic [7:0] OP_FILL_RECT = 8'h02;

endpackage

//--- hdl/framebuffer_ram.sv
`timescale 1ns/1ps
/* framebuffer: byte-wide ram, one write port and a registered read port. */
module framebuffer_ram import panel_geom_pkg::*; (
    input  logic clk,
    input  fb_addr_t wr_addr,
    input  logic [7:0] wr_data,
    input  logic we,
    input  fb_addr_t rd_addr,
    output logic [7:0] rd_data
);
    localparam int DEPTH = 1 << $bits(fb_addr_t);

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr]; // one cycle read latency.
    end

endmodule

//--- hdl/control_subcmd_fillarea.sv
`timescale 1ns/1ps
/* area walker: writes one colour byte per cycle over a rectangle,
   red, green, blue per pixel, row by row. */
module control_subcmd_fillarea import panel_geom_pkg::*; #(
    parameter int PANEL_WIDTH = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  area_t area,
    input  color_t color,
    output fb_addr_t addr,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic done
);
    logic running, enable_q;
    logic last_byte, last_col, last_row;
    byte_idx_t byte_idx;
    col_t col_off;
    row_t row_off;

    assign last_byte = (byte_idx == byte_idx_t'(BYTES_PER_PIXEL - 1));
    assign last_col = (col_off == col_t'(area.width - 1'b1));
    assign last_row = (row_off == row_t'(area.height - 1'b1));

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            enable_q <= 1'b0;
            done <= 1'b0;
            byte_idx <= '0;
            col_off <= '0;
            row_off <= '0;
        end else begin
            enable_q <= enable;
            done <= 1'b0;
            if (!running) begin
                if (enable && !enable_q) begin // start on the rising edge only.
                    byte_idx <= '0;
                    col_off <= '0;
                    row_off <= '0;
                    if (area.width == '0 || area.height == '0)
                        done <= 1'b1;
                    else
                        running <= 1'b1;
                end
            end else if (!last_byte) begin
                byte_idx <= byte_idx + 1'b1;
            end else begin
                byte_idx <= '0;
                if (!last_col) begin
                    col_off <= col_off + 1'b1;
                end else begin
                    col_off <= '0;
                    if (last_row) begin
                        running <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        row_off <= row_off + 1'b1;
                    end
                end
            end
        end
    end

    assign ram_write_enable = running;
    assign addr = '{row: row_t'(area.y + row_off), col: col_t'(area.x + col_off),
                    byte_idx: byte_idx};
    assign data_out = color[2'(BYTES_PER_PIXEL - 1) - byte_idx]; // red goes first.

    // the command must have clipped the area to the panel.
    a_in_panel: assert property (@(posedge clk) disable iff (reset) ram_write_enable |->
        addr.row < PANEL_HEIGHT && addr.col < PANEL_WIDTH && addr.byte_idx < BYTES_PER_PIXEL);

endmodule

//--- hdl/control_cmd_fillpanel.sv
`timescale 1ns/1ps
/* fill panel command: captures a colour, red first,
   and paints every pixel of the panel with it. */
module control_cmd_fillpanel import panel_geom_pkg::*; #(
    parameter int PANEL_WIDTH = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] data_in,
    input  logic enable,
    output fb_addr_t addr,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic ready_for_data,
    output logic done
);
    typedef enum logic {ST_CAPTURE, ST_RUN} state_t;
    state_t state;
    color_t color;
    logic [1:0] bytes_left;
    logic sub_enable, sub_done, local_reset;
    area_t area;

    assign area = '{x: '0, y: '0, width: col_count_t'(PANEL_WIDTH),
                    height: row_count_t'(PANEL_HEIGHT)};

    always_ff @(posedge clk) begin
        if (enable && state == ST_CAPTURE)
            color <= {color[BYTES_PER_PIXEL-2:0], data_in}; // big endian shift-in.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            bytes_left <= 2'(BYTES_PER_PIXEL - 1);
            sub_enable <= 1'b0;
            local_reset <= 1'b0;
            ready_for_data <= 1'b1;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            local_reset <= 1'b0;
            case (state)
                ST_CAPTURE: begin
                    if (enable) begin
                        if (bytes_left == 2'd0) begin
                            ready_for_data <= 1'b0;
                            sub_enable <= 1'b1;
                            state <= ST_RUN;
                        end else begin
                            bytes_left <= bytes_left - 2'd1;
                        end
                    end
                end
                ST_RUN: begin
                    if (sub_done) begin
                        sub_enable <= 1'b0;
                        local_reset <= 1'b1; // re-arm the walker.
                        done <= 1'b1;
                        ready_for_data <= 1'b1;
                        bytes_left <= 2'(BYTES_PER_PIXEL - 1);
                        state <= ST_CAPTURE;
                    end
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

    control_subcmd_fillarea #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_fillarea (
        .clk(clk), .reset(reset || local_reset), .enable(sub_enable),
        .area(area), .color(color), .addr(addr), .data_out(data_out),
        .ram_write_enable(ram_write_enable), .done(sub_done)
    );

endmodule

//--- hdl/control_cmd_fillrect.sv
`timescale 1ns/1ps
/* fill rectangle command: captures x, y, width, height and colour,
   clips the rectangle to the panel and paints it. */
module control_cmd_fillrect import panel_geom_pkg::*; #(
    parameter int PANEL_WIDTH = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] data_in,
    input  logic enable,
    output fb_addr_t addr,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic ready_for_data,
    output logic done
);
    typedef enum logic {ST_CAPTURE, ST_RUN} state_t;
    state_t state;
    logic [2:0] byte_cnt;
    logic [7:0] x_b, y_b, w_b, h_b;
    logic [8:0] room_w, room_h;
    logic outside;
    color_t color;
    area_t area;
    logic sub_enable, sub_done, local_reset;

    always_ff @(posedge clk) begin
        if (enable && state == ST_CAPTURE) begin
            case (byte_cnt)
                3'd0: x_b <= data_in;
                3'd1: y_b <= data_in;
                3'd2: w_b <= data_in;
                3'd3: h_b <= data_in;
                default: color <= {color[BYTES_PER_PIXEL-2:0], data_in};
            endcase
        end
    end

    // clip to the panel edges.
    assign outside = ({1'b0, x_b} >= 9'(PANEL_WIDTH)) || ({1'b0, y_b} >= 9'(PANEL_HEIGHT));
    assign room_w = 9'(PANEL_WIDTH) - {1'b0, x_b};
    assign room_h = 9'(PANEL_HEIGHT) - {1'b0, y_b};
    assign area.x = col_t'(x_b);
    assign area.y = row_t'(y_b);
    assign area.width = outside ? '0 : col_count_t'(({1'b0, w_b} > room_w) ? room_w : {1'b0, w_b});
    assign area.height = outside ? '0 : row_count_t'(({1'b0, h_b} > room_h) ? room_h : {1'b0, h_b});

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            byte_cnt <= '0;
            sub_enable <= 1'b0;
            local_reset <= 1'b0;
            ready_for_data <= 1'b1;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            local_reset <= 1'b0;
            if (state == ST_CAPTURE && enable) begin
                if (byte_cnt == 3'(3 + BYTES_PER_PIXEL)) begin // blue is the last byte.
                    ready_for_data <= 1'b0;
                    sub_enable <= 1'b1;
                    state <= ST_RUN;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end else if (state == ST_RUN && sub_done) begin
                sub_enable <= 1'b0;
                local_reset <= 1'b1;
                done <= 1'b1;
                ready_for_data <= 1'b1;
                byte_cnt <= '0;
                state <= ST_CAPTURE;
            end
        end
    end

    control_subcmd_fillarea #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_fillarea (
        .clk(clk), .reset(reset || local_reset), .enable(sub_enable),
        .area(area), .color(color), .addr(addr), .data_out(data_out),
        .ram_write_enable(ram_write_enable), .done(sub_done)
    );

endmodule

//--- hdl/control_cmd_dispatch.sv
`timescale 1ns/1ps
/* command dispatcher: decodes the opcode, feeds payload bytes to the
   selected command and muxes the command write ports onto the ram. */
module control_cmd_dispatch import panel_geom_pkg::*, panel_bus_pkg::*; #(
    parameter int PANEL_WIDTH = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic clk,
    input  logic reset,
    input  cmd_byte_t cmd,
    output logic cmd_ready,
    output logic busy,
    output fb_addr_t ram_addr,
    output logic [7:0] ram_data,
    output logic ram_we
);
    typedef enum logic {ST_IDLE, ST_ROUTE} state_t;
    state_t state;
    logic sel_rect;
    logic take, act_ready, act_done;
    logic panel_en, panel_we, panel_ready, panel_done;
    logic rect_en, rect_we, rect_ready, rect_done;
    logic [7:0] panel_data, rect_data;
    fb_addr_t panel_addr, rect_addr;

    assign act_ready = sel_rect ? rect_ready : panel_ready;
    assign act_done = sel_rect ? rect_done : panel_done;
    // hold off the next opcode while the command signals done.
    assign cmd_ready = (state == ST_IDLE) || (act_ready && !act_done);
    assign take = cmd.valid && cmd_ready;
    assign panel_en = take && (state == ST_ROUTE) && !sel_rect;
    assign rect_en = take && (state == ST_ROUTE) && sel_rect;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            sel_rect <= 1'b0;
            busy <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take && (cmd.data == OP_FILL_PANEL || cmd.data == OP_FILL_RECT)) begin
                        state <= ST_ROUTE;
                        sel_rect <= (cmd.data == OP_FILL_RECT);
                        busy <= 1'b1;
                    end // unknown opcodes fall through.
                end
                ST_ROUTE: begin
                    if (act_done) begin
                        state <= ST_IDLE;
                        busy <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    control_cmd_fillpanel #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_fillpanel (
        .clk(clk), .reset(reset), .data_in(cmd.data), .enable(panel_en),
        .addr(panel_addr), .data_out(panel_data), .ram_write_enable(panel_we),
        .ready_for_data(panel_ready), .done(panel_done)
    );

    control_cmd_fillrect #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_fillrect (
        .clk(clk), .reset(reset), .data_in(cmd.data), .enable(rect_en),
        .addr(rect_addr), .data_out(rect_data), .ram_write_enable(rect_we),
        .ready_for_data(rect_ready), .done(rect_done)
    );

    assign ram_we = panel_we || rect_we;
    assign ram_addr = sel_rect ? rect_addr : panel_addr;
    assign ram_data = sel_rect ? rect_data : panel_data;

    a_one_writer: assert property (@(posedge clk) disable iff (reset) !(panel_we && rect_we));

endmodule

//--- hdl/apb_host_port.sv
`timescale 1ns/1ps
/* APB slave: passes command bytes on, reports status and
   reads the framebuffer back through an auto-incrementing pointer. */
module apb_host_port import panel_geom_pkg::*, panel_bus_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output cmd_byte_t cmd,
    input  logic cmd_ready,
    input  logic busy,
    output fb_addr_t rd_addr,
    input  logic [7:0] rd_data
);
    logic access;
    logic rd_wait;
    logic ptr_hi;
    fb_addr_t rd_ptr;

    assign access = apb_req.psel && apb_req.penable;

    // the bus holds the byte stable until pready, so the request is the command.
    assign cmd.valid = access && apb_req.pwrite && (apb_req.paddr == REG_CMD);
    assign cmd.data = apb_req.pwdata;
    assign rd_addr = rd_ptr;

    always_comb begin
        apb_rsp = '0;
        if (access) begin
            case (apb_req.paddr)
                REG_CMD: begin
                    apb_rsp.pready = apb_req.pwrite ? cmd_ready : 1'b1;
                    apb_rsp.pslverr = !apb_req.pwrite; // write only.
                end
                REG_STATUS: begin
                    apb_rsp.pready = 1'b1;
                    apb_rsp.prdata = {7'b0, busy};
                end
                REG_FB_ADDR: apb_rsp.pready = 1'b1;
                REG_FB_DATA: begin
                    apb_rsp.pready = apb_req.pwrite || rd_wait; // ram read takes a cycle.
                    apb_rsp.prdata = rd_data;
                end
                default: begin
                    apb_rsp.pready = 1'b1;
                    apb_rsp.pslverr = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait <= 1'b0;
            ptr_hi <= 1'b0;
            rd_ptr <= '0;
        end else begin
            rd_wait <= access && !apb_req.pwrite && (apb_req.paddr == REG_FB_DATA)
                       && !rd_wait;
            if (access && apb_req.pwrite && (apb_req.paddr == REG_FB_ADDR)) begin
                ptr_hi <= !ptr_hi;
                if (ptr_hi)
                    rd_ptr[10:8] <= apb_req.pwdata[2:0];
                else
                    rd_ptr[7:0] <= apb_req.pwdata;
            end
            if (rd_wait) begin
                // skip the unused fourth byte slot of each pixel.
                if (rd_ptr.byte_idx == byte_idx_t'(BYTES_PER_PIXEL - 1)) begin
                    rd_ptr.byte_idx <= '0;
                    {rd_ptr.row, rd_ptr.col} <= {rd_ptr.row, rd_ptr.col} + 1'b1;
                end else begin
                    rd_ptr.byte_idx <= rd_ptr.byte_idx + 1'b1;
                end
            end
        end
    end

    // a stalled command byte stays offered until the dispatcher takes it.
    a_cmd_held: assert property (@(posedge clk) disable iff (reset)
        cmd.valid && !cmd_ready |=> cmd.valid && $stable(cmd.data));

endmodule

//--- hdl/panel_ctrl_top.sv
`timescale 1ns/1ps
/* LED panel command processor: APB host port, command dispatcher
   and framebuffer ram. */
module panel_ctrl_top import panel_geom_pkg::*, panel_bus_pkg::*; #(
    parameter int PANEL_WIDTH = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic clk,
    input  logic reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);
    cmd_byte_t cmd;
    logic cmd_ready, busy, ram_we;
    logic [7:0] ram_data, rd_data;
    fb_addr_t ram_addr, rd_addr;

    apb_host_port u_host (
        .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .cmd(cmd), .cmd_ready(cmd_ready), .busy(busy),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    control_cmd_dispatch #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_dispatch (
        .clk(clk), .reset(reset), .cmd(cmd), .cmd_ready(cmd_ready), .busy(busy),
        .ram_addr(ram_addr), .ram_data(ram_data), .ram_we(ram_we)
    );

    framebuffer_ram u_fb (
        .clk(clk), .wr_addr(ram_addr), .wr_data(ram_data), .we(ram_we),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

//--- tests/tb_panel_ctrl.sv
`timescale 1ns/1ps
/* testbench for the LED panel command processor. It applies a table of fill commands,
   keeps a framebuffer model and reads the whole panel back through APB. */
module tb_panel_ctrl import panel_bus_pkg::*; ();

    localparam int PANEL_WIDTH = 32;
    localparam int PANEL_HEIGHT = 16;
    localparam int FB_BYTES = PANEL_WIDTH * PANEL_HEIGHT * 3;
    localparam int PREADY_TIMEOUT = 4000; // longer than a whole-panel fill.
    localparam int BUSY_POLLS = 2000;
    localparam int NUM_STIM = 12;

    typedef struct packed {
        logic [7:0] op;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] w;
        logic [7:0] h;
        logic [23:0] color;
        logic rand_color;
        logic chain; // next entry is sent without waiting for idle.
    } stim_t;

    logic clk;
    logic reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [7:0] fb_model [FB_BYTES];
    logic [31:0] lcg_state;
    int checks;
    int value_errors;
    int other_errors;
    int cmd_stalls;
    event abort_ev;
    string abort_why;

    stim_t stim_tab [NUM_STIM] = '{
        '{OP_FILL_PANEL, 8'd0, 8'd0, 8'd0, 8'd0, 24'h102030, 1'b0, 1'b0},
        '{OP_FILL_RECT, 8'd4, 8'd3, 8'd5, 8'd4, 24'ha0b0c0, 1'b0, 1'b0},
        '{OP_FILL_RECT, 8'd28, 8'd13, 8'd10, 8'd9, 24'h0, 1'b1, 1'b0},  // right and bottom clip.
        '{OP_FILL_RECT, 8'd40, 8'd2, 8'd3, 8'd3, 24'hffffff, 1'b0, 1'b0},
        '{OP_FILL_RECT, 8'd1, 8'd10, 8'd6, 8'd2, 24'h0, 1'b1, 1'b1},
        '{OP_FILL_RECT, 8'd0, 8'd0, 8'd32, 8'd8, 24'h0, 1'b1, 1'b1},
        '{OP_FILL_RECT, 8'd10, 8'd5, 8'd200, 8'd1, 24'h0, 1'b1, 1'b0},
        '{8'h5a, 8'd0, 8'd0, 8'd0, 8'd0, 24'h0, 1'b0, 1'b1},             // unknown opcode.
        '{OP_FILL_RECT, 8'd8, 8'd8, 8'd8, 8'd8, 24'h010203, 1'b0, 1'b0},
        '{OP_FILL_RECT, 8'd3, 8'd20, 8'd4, 8'd4, 24'h123456, 1'b0, 1'b0},
        '{OP_FILL_PANEL, 8'd0, 8'd0, 8'd0, 8'd0, 24'h0, 1'b1, 1'b1},
        '{OP_FILL_RECT, 8'd30, 8'd15, 8'd2, 8'd1, 24'h0, 1'b1, 1'b0}
    };

    panel_ctrl_top #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_dut (
        .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        @(abort_ev);
        $display("ERROR at %0t ns: %s", $time, abort_why);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // parks the caller while the abort process ends the run.
    task automatic abort_run(input string why);
        abort_why = why;
        -> abort_ev;
        forever @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("FAILED at %0t ns: %s expected 0x%02h got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    // runs one APB transfer and samples the response at the falling edge.
    task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready && waits < PREADY_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (!apb_rsp.pready)
            abort_run($sformatf("pready never rose for offset 0x%h", addr));
        if (write && addr == REG_CMD)
            cmd_stalls += waits;
        else if (!write && addr == REG_FB_DATA)
            check_value("apb_rsp.pready wait cycles (REG_FB_DATA read)", 8'd1, 8'(waits));
        else
            check_value("apb_rsp.pready wait cycles", 8'd0, 8'(waits));
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        logic err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_value("apb_rsp.pslverr", 8'h00, {7'b0, err});
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [7:0] data);
        logic err;
        apb_xfer(1'b0, addr, 8'h00, data, err);
        check_value("apb_rsp.pslverr", 8'h00, {7'b0, err});
    endtask

    task automatic wait_idle();
        logic [7:0] status;
        int polls;
        polls = 0;
        apb_read(REG_STATUS, status);
        while (status[0] && polls < BUSY_POLLS) begin
            apb_read(REG_STATUS, status);
            polls++;
        end
        if (status[0])
            abort_run("busy never cleared after a command");
    endtask

    task automatic send_cmd(input stim_t s, input logic [23:0] color);
        apb_write(REG_CMD, s.op);
        if (s.op == OP_FILL_RECT) begin
            apb_write(REG_CMD, s.x);
            apb_write(REG_CMD, s.y);
            apb_write(REG_CMD, s.w);
            apb_write(REG_CMD, s.h);
        end
        if (s.op == OP_FILL_PANEL || s.op == OP_FILL_RECT) begin
            apb_write(REG_CMD, color[23:16]); // red first.
            apb_write(REG_CMD, color[15:8]);
            apb_write(REG_CMD, color[7:0]);
        end
    endtask

    // pixels outside the panel simply never match the loop.
    function automatic void model_fill(input int x0, input int y0, input int w, input int h,
                                       input logic [23:0] color);
        int idx;
        for (int r = 0; r < PANEL_HEIGHT; r++) begin
            for (int c = 0; c < PANEL_WIDTH; c++) begin
                if (r >= y0 && r < y0 + h && c >= x0 && c < x0 + w) begin
                    idx = (r * PANEL_WIDTH + c) * 3;
                    fb_model[idx] = color[23:16];
                    fb_model[idx + 1] = color[15:8];
                    fb_model[idx + 2] = color[7:0];
                end
            end
        end
    endfunction

    task automatic check_panel();
        logic [7:0] got;
        apb_write(REG_FB_ADDR, 8'h00); // low byte first and then the high bits.
        apb_write(REG_FB_ADDR, 8'h00);
        for (int i = 0; i < FB_BYTES; i++) begin
            apb_read(REG_FB_DATA, got);
            check_value($sformatf("apb_rsp.prdata (framebuffer byte %0d)", i), fb_model[i], got);
        end
    endtask

    initial begin
        logic [7:0] rdata;
        logic err;
        logic [23:0] color;
        reset = 1'b1;
        apb_req = '0;
        lcg_state = 32'h2e1b_ea0e;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        cmd_stalls = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        apb_read(REG_STATUS, rdata);
        check_value("apb_rsp.prdata (REG_STATUS)", 8'h00, rdata);

        apb_xfer(1'b0, REG_CMD, 8'h00, rdata, err);
        check_value("apb_rsp.pslverr (REG_CMD read)", 8'h01, {7'b0, err});
        apb_xfer(1'b1, 4'h2, 8'h33, rdata, err);
        check_value("apb_rsp.pslverr (offset 0x2 write)", 8'h01, {7'b0, err});
        apb_xfer(1'b0, 4'h6, 8'h00, rdata, err);
        check_value("apb_rsp.pslverr (offset 0x6 read)", 8'h01, {7'b0, err});

        for (int n = 0; n < NUM_STIM; n++) begin
            color = stim_tab[n].color;
            if (stim_tab[n].rand_color) begin
                lcg_state = lcg_next(lcg_state);
                color = lcg_state[31:8];
            end
            send_cmd(stim_tab[n], color);
            if (stim_tab[n].op == OP_FILL_PANEL)
                model_fill(0, 0, PANEL_WIDTH, PANEL_HEIGHT, color);
            else if (stim_tab[n].op == OP_FILL_RECT)
                model_fill(stim_tab[n].x, stim_tab[n].y, stim_tab[n].w, stim_tab[n].h, color);
            if (!stim_tab[n].chain) begin
                wait_idle();
                check_panel();
            end
        end

        // chained commands have to meet a running fill.
        assert (cmd_stalls > 0) else begin
            other_errors++;
            $display("ERROR: no command write was ever held off by pready");
        end

        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- panel_ctrl.f
hdl/panel_geom_pkg.sv
hdl/panel_bus_pkg.sv
hdl/framebuffer_ram.sv
hdl/control_subcmd_fillarea.sv
hdl/control_cmd_fillpanel.sv
hdl/control_cmd_fillrect.sv
hdl/control_cmd_dispatch.sv
hdl/apb_host_port.sv
hdl/panel_ctrl_top.sv
tests/tb_panel_ctrl.sv

//--- Makefile
# Verilator build and run for the LED panel command processor.
VERILATOR ?= verilator
TOP       ?= tb_panel_ctrl
FILELIST  ?= panel_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
